// File: common/ad9516_init_table.svh
`ifndef AD9516_INIT_TABLE_SVH
`define AD9516_INIT_TABLE_SVH

localparam frame_t init_table [init_count] = '{
    24'h000099,  // Serial port config.
    24'h000100,
    24'h000210,
    24'h000343,
    24'h000401,
    24'h00107C,  // Charge pump current.
    24'h001101,
    24'h001200,
    24'h001308,
    24'h00140C,
    24'h001500,
    24'h001605,
    24'h001700,
    24'h001806,
    24'h001900,
    24'h001A00,
    24'h001B00,
    24'h001C44,
    24'h001D00,
    24'h001E00,
    24'h001F0E,
    24'h00A000,
    24'h00A100,
    24'h00A200,
    24'h00A300,
    24'h00A400,
    24'h00A500,
    24'h00A600,
    24'h00A700,
    24'h00A800,
    24'h00A900,
    24'h00AA00,
    24'h00AB00,
    24'h00F008,  // LVPECL outputs.
    24'h00F108,
    24'h00F208,
    24'h00F308,
    24'h00F408,
    24'h00F508,
    24'h014042,  // LVDS/CMOS outputs.
    24'h014142,
    24'h014242,
    24'h014342,
    24'h019000,  // Output dividers.
    24'h019100,
    24'h019200,
    24'h019300,
    24'h019400,
    24'h019500,
    24'h019600,
    24'h019700,
    24'h019800,
    24'h019944,
    24'h019A00,
    24'h019B44,
    24'h019C00,
    24'h019D00,
    24'h019E22,
    24'h019F00,
    24'h01A011,
    24'h01A100,
    24'h01A200,
    24'h01A300,
    24'h01E002,
    24'h01E102,
    24'h023000,
    24'h023100,
    24'h023201,  // Update registers.
    24'h001807,  // Start VCO calibration.
    24'h023201
};

`endif

// File: common/ad9516_pkg.sv
package ad9516_pkg;

    // One serial frame is command, address and data, MSB first.
    localparam int frame_bits = 24;

    localparam int init_count = 70;  // Power-up table length.

    typedef logic [frame_bits-1:0] frame_t;

    typedef logic [7:0] readback_t;

    // Read command for register 0x01F, the PLL readback register.
    localparam frame_t read_cmd = 24'h801F00;

    typedef enum logic [2:0]
    {
        st_idle,
        st_load,
        st_write,
        st_wait,
        st_read
    } seq_state_t;

endpackage

// File: spi/spi_frame_tx.sv
`timescale 1ns/10ps

module spi_frame_tx #(
    parameter int frame_cycles = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_start,
    input  ad9516_pkg::frame_t frame_word,
    output logic               spi_clk,
    output logic               spi_mosi,
    output logic               spi_le,
    output logic               bit_sample,
    output logic               frame_done
);
    import ad9516_pkg::*;

    localparam int slot_w    = $clog2(frame_cycles);
    localparam int last_high = 2 * frame_bits - 1;  // Slot of the 24th high phase.

    frame_t            shift_reg;
    logic              bit_phase;
    logic              busy;
    logic [slot_w-1:0] slot_cnt;

    assign spi_clk = bit_phase;

    always_ff @(posedge clk)
    begin
        if (frame_start)
            shift_reg <= frame_word;
        else if (!spi_le && bit_phase)
            shift_reg <= {shift_reg[frame_bits-2:0], 1'b0};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy       <= 1'b0;
            slot_cnt   <= '0;
            bit_phase  <= 1'b0;
            spi_mosi   <= 1'b0;
            spi_le     <= 1'b1;
            bit_sample <= 1'b0;
            frame_done <= 1'b0;
        end
        else
        begin
            bit_sample <= 1'b0;
            frame_done <= 1'b0;
            if (frame_start)
            begin
                busy      <= 1'b1;
                slot_cnt  <= '0;
                bit_phase <= 1'b0;
                spi_le    <= 1'b0;
                spi_mosi  <= frame_word[frame_bits-1];  // MSB first.
            end
            else if (busy)
            begin
                slot_cnt <= slot_cnt + 1'b1;
                // Quiet gap runs until the fixed slot ends.
                if (slot_cnt == slot_w'(frame_cycles - 2))
                begin
                    busy       <= 1'b0;
                    frame_done <= 1'b1;
                end
                if (!spi_le)
                begin
                    if (!bit_phase)
                    begin
                        bit_phase  <= 1'b1;  // Rising spi_clk.
                        bit_sample <= 1'b1;
                    end
                    else
                    begin
                        bit_phase <= 1'b0;
                        if (slot_cnt == slot_w'(last_high))
                            spi_le <= 1'b1;  // Latch the frame.
                        else
                            spi_mosi <= shift_reg[frame_bits-2];
                    end
                end
            end
        end
    end

endmodule

// File: spi/spi_readback_rx.sv
`timescale 1ns/10ps

module spi_readback_rx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  read_active,
    input  logic                  bit_sample,
    input  logic                  spi_miso,
    output ad9516_pkg::readback_t led
);
    import ad9516_pkg::*;

    localparam int cnt_w      = $clog2(frame_bits + 1);
    localparam int byte_bits  = $bits(readback_t);
    localparam int data_first = frame_bits - byte_bits;  // Data byte is the tail.

    logic [cnt_w-1:0] bit_cnt;
    readback_t        shift_reg;
    logic             byte_ready;

    always_ff @(posedge clk)
    begin
        if (read_active && bit_sample && (bit_cnt >= cnt_w'(data_first)))
            shift_reg <= {shift_reg[byte_bits-2:0], spi_miso};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt    <= '0;
            byte_ready <= 1'b0;
            led        <= '1;  // All LEDs off.
        end
        else
        begin
            byte_ready <= 1'b0;
            if (!read_active)
                bit_cnt <= '0;
            else if (bit_sample)
            begin
                bit_cnt    <= bit_cnt + 1'b1;
                byte_ready <= (bit_cnt == cnt_w'(frame_bits - 1));
            end
            if (byte_ready)
                led <= shift_reg;
        end
    end

endmodule

// File: hw/config_sequencer.sv
`timescale 1ns/10ps

module config_sequencer #(
    parameter int wait_cycles = 50_000_000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_done,
    output logic               frame_start,
    output ad9516_pkg::frame_t frame_word,
    output logic               read_active
);
    import ad9516_pkg::*;

    `include "ad9516_init_table.svh"

    localparam int idx_w  = $clog2(init_count);
    localparam int wait_w = $clog2(wait_cycles + 1);

    seq_state_t        state;
    logic [idx_w-1:0]  table_idx;
    logic [wait_w-1:0] wait_cnt;
    logic              read_go;

    assign read_go     = (state == st_wait) && (wait_cnt == '0);  // Wait expired.
    assign frame_start = (state == st_load) || read_go;
    assign frame_word  = read_go ? read_cmd : init_table[table_idx];
    assign read_active = read_go || (state == st_read);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            table_idx <= '0;
            wait_cnt  <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    state <= st_load;
                end
                st_load:
                begin
                    state <= st_write;  // Frame issued this cycle.
                end
                st_write:
                begin
                    if (frame_done)
                    begin
                        if (table_idx == idx_w'(init_count - 1))
                        begin
                            wait_cnt <= wait_w'(wait_cycles);
                            state    <= st_wait;
                        end
                        else
                        begin
                            table_idx <= table_idx + 1'b1;
                            state     <= st_load;
                        end
                    end
                end
                st_wait:
                begin
                    if (wait_cnt == '0)
                        state <= st_read;
                    else
                        wait_cnt <= wait_cnt - 1'b1;
                end
                st_read:
                begin
                    // Loop back for the next readback.
                    if (frame_done)
                    begin
                        wait_cnt <= wait_w'(wait_cycles);
                        state    <= st_wait;
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: hw/ad9516_config_top.sv
`timescale 1ns/10ps

module ad9516_config_top #(
    parameter int frame_cycles = 256,
    parameter int wait_cycles  = 50_000_000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  spi_miso,
    output logic                  spi_clk,
    output logic                  spi_mosi,
    output logic                  spi_le,
    output ad9516_pkg::readback_t led
);
    import ad9516_pkg::*;

    frame_t frame_word;
    logic   frame_start;
    logic   frame_done;
    logic   read_active;
    logic   bit_sample;

    config_sequencer #(
        .wait_cycles (wait_cycles)
    ) u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_done  (frame_done),
        .frame_start (frame_start),
        .frame_word  (frame_word),
        .read_active (read_active)
    );

    spi_frame_tx #(
        .frame_cycles (frame_cycles)
    ) u_frame_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .frame_word  (frame_word),
        .spi_clk     (spi_clk),
        .spi_mosi    (spi_mosi),
        .spi_le      (spi_le),
        .bit_sample  (bit_sample),
        .frame_done  (frame_done)
    );

    spi_readback_rx u_readback_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_active (read_active),
        .bit_sample  (bit_sample),
        .spi_miso    (spi_miso),
        .led         (led)
    );

endmodule

// File: tests/ad9516_properties.sv
`timescale 1ns/10ps

module ad9516_properties (
    input logic clk,
    input logic rst_n,
    input logic spi_clk,
    input logic spi_mosi,
    input logic spi_le,
    input logic frame_done
);

    // Serial clock idles low between frames.
    le_clk_low: assert property (@(posedge clk) disable iff (!rst_n) spi_le |-> !spi_clk)
    else $error("spi_clk is high while spi_le is high");

    mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
        spi_clk |-> $stable(spi_mosi))
    else $error("spi_mosi changed while spi_clk was high");

    // Slot ends only after the frame is latched.
    done_after_le: assert property (@(posedge clk) disable iff (!rst_n) frame_done |-> spi_le)
    else $error("frame_done pulsed while spi_le was low");

endmodule

bind spi_frame_tx ad9516_properties u_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .spi_clk    (spi_clk),
    .spi_mosi   (spi_mosi),
    .spi_le     (spi_le),
    .frame_done (frame_done)
);

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released on a falling edge.
    end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/10ps

module tb_top;

    localparam int frame_cycles   = 64;
    localparam int wait_cycles    = 100;
    localparam int write_count    = 70;
    localparam int read_count     = 4;
    localparam int word_bits      = 24;
    localparam int data_first     = 16;  // Data byte is bits 17 to 24.
    localparam int data_words     = write_count + 1 + read_count;
    localparam int timeout_cycles = 16 + write_count * frame_cycles
                                    + read_count * (wait_cycles + frame_cycles) + 200;
    // Latched to next spi_le fall, one frame slot plus the wait and the load cycle.
    localparam int read_gap       = frame_cycles + wait_cycles + 1 - 2 * word_bits;

    logic        clk;
    logic        rst_n;
    logic        spi_miso = 1'b0;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_le;
    logic [7:0]  led;
    logic [23:0] test_data [data_words];
    logic [23:0] rx_word = '0;
    int          rx_bits = 0;
    bit          in_frame = 1'b0;
    int          frames_seen = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          read_done_age = 1000;
    int          led_changes = 0;
    int          led_glitches = 0;
    int          le_rise_cycle = 0;
    int          le_fall_cycle = 0;
    logic [7:0]  led_prev = 8'hff;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ad9516_config_top #(
        .frame_cycles (frame_cycles),
        .wait_cycles  (wait_cycles)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_miso (spi_miso),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_le   (spi_le),
        .led      (led)
    );

    function automatic logic miso_bit(input int read_idx, input int bit_idx);
        logic [7:0] data;
        if (read_idx < 0 || read_idx >= read_count || bit_idx < data_first ||
            bit_idx >= word_bits)
            return 1'b0;
        data = test_data[write_count + 1 + read_idx][7:0];
        return data[word_bits - 1 - bit_idx];
    endfunction

    task automatic check_frame(input int idx, input logic [23:0] word, input int bits);
        logic [23:0] expected;
        begin
            expected = (idx < write_count) ? test_data[idx] : test_data[write_count];
            assert (bits == word_bits)
            else
            begin
                $display("CHECK FAILED frame %0d spi_clk pulses: got 0x%0h, expected 0x%0h",
                         idx, bits, word_bits);
                errors++;
            end
            assert (word === expected)
            else
            begin
                $display("CHECK FAILED frame %0d spi_mosi word: got 0x%06h, expected 0x%06h",
                         idx, word, expected);
                errors++;
            end
        end
    endtask

    task report_test(input string name, input int mark);
        begin
            tests_run++;
            if (errors == mark)
                $display("PASS %s", name);
            else
            begin
                tests_failed++;
                $display("FAIL %s with %0d errors", name, errors - mark);
            end
        end
    endtask

    task print_counts;
        begin
            $display("Tests run: %0d, failed: %0d, check errors: %0d",
                     tests_run, tests_failed, errors);
        end
    endtask

    // Serial slave model.
    always @(negedge spi_le)
    begin
        le_fall_cycle = cycle_count;
        in_frame      = 1'b1;
        rx_bits       = 0;
    end

    always @(posedge spi_clk)
    begin
        if (in_frame && !spi_le)
        begin
            rx_word = {rx_word[22:0], spi_mosi};
            rx_bits++;
        end
    end

    always @(posedge spi_le)
    begin
        if (in_frame)
        begin
            in_frame = 1'b0;
            le_rise_cycle = cycle_count;
            check_frame(frames_seen, rx_word, rx_bits);
            if (frames_seen >= write_count)
                read_done_age = 0;  // Read frame latched.
            frames_seen++;
        end
    end

    // Miso moves only in the low half of a bit.
    always @(negedge clk)
    begin
        if (!spi_clk)
            spi_miso = miso_bit(frames_seen - write_count, rx_bits);
    end

    always @(negedge clk)
    begin
        if (rst_n && led !== led_prev)
        begin
            led_changes++;
            assert (read_done_age <= 2)
            else
            begin
                $display("led changed from 0x%02h to 0x%02h outside a read frame completion",
                         led_prev, led);
                led_glitches++;
            end
        end
        led_prev = led;
        read_done_age++;
    end

    initial
    begin
        while (cycle_count < timeout_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d clock cycles with %0d frames seen", cycle_count, frames_seen);
        print_counts();
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        int mark;
        int idle_cycles;
        $readmemh("tests/ad9516_tests.txt", test_data);
        assert (!$isunknown(test_data[data_words - 1]))
        else
        begin
            $display("Data file tests/ad9516_tests.txt is missing or too short");
            errors++;
        end

        mark = errors;
        idle_cycles = 0;
        @(negedge clk);
        while (spi_le === 1'b1)
        begin
            assert (spi_clk === 1'b0)
            else
            begin
                $display("CHECK FAILED idle spi_clk: got 0x%0h, expected 0x0", spi_clk);
                errors++;
            end
            assert (led === 8'hff)
            else
            begin
                $display("CHECK FAILED idle led: got 0x%02h, expected 0xff", led);
                errors++;
            end
            idle_cycles++;
            @(negedge clk);
        end
        assert (rst_n === 1'b1 && idle_cycles >= 16)
        else
        begin
            $display("First frame started after %0d cycles, before reset ended", idle_cycles);
            errors++;
        end
        report_test("reset_idle", mark);

        mark = errors;
        wait (frames_seen >= write_count);
        report_test("init_writes", mark);

        for (int n = 0; n < read_count; n++)
        begin
            mark = errors;
            wait (frames_seen >= write_count + 1 + n);
            repeat (2) @(negedge clk);
            assert (led === test_data[write_count + 1 + n][7:0])
            else
            begin
                $display("CHECK FAILED led after read %0d: got 0x%02h, expected 0x%02h",
                         n, led, test_data[write_count + 1 + n][7:0]);
                errors++;
            end
            report_test($sformatf("readback_%0d", n), mark);
        end

        mark = errors;
        wait (in_frame);  // Next read frame after the last checked one.
        assert (le_fall_cycle - le_rise_cycle == read_gap)
        else
        begin
            $display("CHECK FAILED spi_le high time between reads: got 0x%0h, expected 0x%0h",
                     le_fall_cycle - le_rise_cycle, read_gap);
            errors++;
        end
        report_test("loop_repeat", mark);

        mark = errors;
        assert (led_changes == read_count && led_glitches == 0)
        else
        begin
            $display("led changed %0d times, %0d of them outside a read completion",
                     led_changes, led_glitches);
            errors++;
        end
        report_test("led_hold", mark);

        print_counts();
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/ad9516_pkg.sv
spi/spi_frame_tx.sv
spi/spi_readback_rx.sv
hw/config_sequencer.sv
hw/ad9516_config_top.sv
tests/ad9516_properties.sv
tests/tb_clock_gen.sv
tests/tb_top.sv

// File: Bender.yml
package:
  name: ad9516_config

sources:
  - include_dirs:
      - common
    files:
      - common/ad9516_pkg.sv
      - spi/spi_frame_tx.sv
      - spi/spi_readback_rx.sv
      - hw/config_sequencer.sv
      - hw/ad9516_config_top.sv
  - target: test
    files:
      - tests/ad9516_properties.sv
      - tests/tb_clock_gen.sv
      - tests/tb_top.sv

// File: tests/ad9516_tests.txt
// One hex word per line: 70 power-up write frames, then the read command,
// then the data bytes returned on spi_miso by the successive read frames.
000099
000100
000210
000343
000401
00107C
001101
001200
001308
00140C
001500
001605
001700
001806
001900
001A00
001B00
001C44
001D00
001E00
001F0E
00A000
00A100
00A200
00A300
00A400
00A500
00A600
00A700
00A800
00A900
00AA00
00AB00
00F008
00F108
00F208
00F308
00F408
00F508
014042
014142
014242
014342
019000
019100
019200
019300
019400
019500
019600
019700
019800
019944
019A00
019B44
019C00
019D00
019E22
019F00
01A011
01A100
01A200
01A300
01E002
01E102
023000
023100
023201
001807
023201
801F00
01
5A
A5
3C
